/* common/rvIsaPkg.sv */
package rvIsaPkg;

    // ********************
    // Widths
    // ********************
    localparam int xlen     = 32;
    localparam int instrW   = 32;
    localparam int regAddrW = 5;
    localparam int numRegs  = 32;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011
    } opcodeE;

    // ALU operations
    // Low three bits follow funct3, bit 3 is the funct7[5] variant
    typedef enum logic [3:0] {
        aluAdd   = 4'b0000,
        aluSll   = 4'b0001,
        aluSlt   = 4'b0010,
        aluSltu  = 4'b0011,
        aluXor   = 4'b0100,
        aluSrl   = 4'b0101,
        aluOr    = 4'b0110,
        aluAnd   = 4'b0111,
        aluSub   = 4'b1000,
        aluSra   = 4'b1101,
        aluPassB = 4'b1111   // LUI only
    } aluOpE;

    // Branch funct3 codes
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCondE;

endpackage

/* common/pipePkg.sv */
package pipePkg;
    import rvIsaPkg::*;

    // ALU operand A source
    typedef enum logic [1:0] {
        srcARs1  = 2'd0,
        srcAPc   = 2'd1,
        srcAZero = 2'd2
    } srcASelE;

    // ALU operand B source
    typedef enum logic {
        srcBRs2 = 1'b0,
        srcBImm = 1'b1
    } srcBSelE;

    // ********************
    // Stage records
    // ********************

    // Decode register, about 158 bits
    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     pc;
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic [xlen-1:0]     rs1Data;
        logic [xlen-1:0]     rs2Data;
        logic [xlen-1:0]     imm;
        aluOpE               aluOp;
        srcASelE             srcASel;
        srcBSelE             srcBSel;
        logic                isBranch;
        branchCondE          branchCond;
        logic                isJump;
        logic                jumpReg;     // JALR, target base is rs1
        logic                regWrite;
        logic [regAddrW-1:0] rd;
    } decodedT;

    // Execute register, also the result-stage copy
    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     result;
        logic                regWrite;
        logic [regAddrW-1:0] rd;
        logic                taken;
        logic [xlen-1:0]     target;
    } execT;

    // Retire port payload
    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [regAddrW-1:0] rd;
        logic                regWrite;
        logic [xlen-1:0]     data;
        logic                taken;
        logic [xlen-1:0]     target;
    } retireT;

endpackage

/* decode/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic [rvIsaPkg::regAddrW-1:0] rs1,
    input  logic [rvIsaPkg::regAddrW-1:0] rs2,
    input  logic                          wrEn,
    input  logic [rvIsaPkg::regAddrW-1:0] wrAddr,
    input  logic [rvIsaPkg::xlen-1:0]     wrData,
    output logic [rvIsaPkg::xlen-1:0]     rs1Data,
    output logic [rvIsaPkg::xlen-1:0]     rs2Data
);
    import rvIsaPkg::*;

    logic [xlen-1:0] regs [numRegs];

    // One read port with x0 tie-off and write-through
    function automatic logic [xlen-1:0] readPort(input logic [regAddrW-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wrEn && (wrAddr == idx)) begin
            return wrData;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rs1Data = readPort(rs1);
    assign rs2Data = readPort(rs2);

endmodule

/* decode/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic                          stall,
    input  logic                          inValid,
    input  logic [rvIsaPkg::instrW-1:0]   inInstr,
    input  logic [rvIsaPkg::xlen-1:0]     inPc,
    input  logic                          wrEn,
    input  logic [rvIsaPkg::regAddrW-1:0] wrAddr,
    input  logic [rvIsaPkg::xlen-1:0]     wrData,
    input  logic                          squash,
    output pipePkg::decodedT              dec
);
    import rvIsaPkg::*;
    import pipePkg::*;

    decodedT         nextDec;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] immI, immU, immJ, immB;
    logic [xlen-1:0] rs1Data, rs2Data;

    // funct3 plus the alternate bit maps straight onto aluOpE
    function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
        return aluOpE'({alt, f3});
    endfunction

    regFile regFile0 (
        .Clk     (Clk),
        .rstN    (rstN),
        .rs1     (inInstr[19:15]),
        .rs2     (inInstr[24:20]),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    // ********************
    // Field split
    // ********************
    assign opcode = inInstr[6:0];
    assign funct3 = inInstr[14:12];

    // Immediates per format
    assign immI = {{20{inInstr[31]}}, inInstr[31:20]};
    assign immU = {inInstr[31:12], 12'b0};
    assign immJ = {{12{inInstr[31]}}, inInstr[19:12], inInstr[20], inInstr[30:21], 1'b0};
    assign immB = {{20{inInstr[31]}}, inInstr[7], inInstr[30:25], inInstr[11:8], 1'b0};

    always_comb begin
        // Defaults describe an instruction with no effect
        nextDec            = '0;
        nextDec.valid      = inValid;
        nextDec.pc         = inPc;
        nextDec.rs1        = inInstr[19:15];
        nextDec.rs2        = inInstr[24:20];
        nextDec.rs1Data    = rs1Data;
        nextDec.rs2Data    = rs2Data;
        nextDec.rd         = inInstr[11:7];
        nextDec.imm        = immI;
        nextDec.aluOp      = aluAdd;
        nextDec.srcASel    = srcARs1;
        nextDec.srcBSel    = srcBRs2;
        nextDec.branchCond = branchCondE'(funct3);
        case (opcode)
            opReg: begin
                nextDec.aluOp    = aluFromFunct(funct3, inInstr[30]);
                nextDec.regWrite = 1'b1;
            end
            opImm: begin
                // Only the right shifts use bit 30 here
                nextDec.aluOp    = aluFromFunct(funct3, (funct3 == 3'b101) && inInstr[30]);
                nextDec.srcBSel  = srcBImm;
                nextDec.regWrite = 1'b1;
            end
            opLui: begin
                nextDec.imm      = immU;
                nextDec.aluOp    = aluPassB;
                nextDec.srcASel  = srcAZero;
                nextDec.srcBSel  = srcBImm;
                nextDec.regWrite = 1'b1;
            end
            opAuipc: begin
                nextDec.imm      = immU;
                nextDec.srcASel  = srcAPc;
                nextDec.srcBSel  = srcBImm;
                nextDec.regWrite = 1'b1;
            end
            opJal: begin
                nextDec.imm      = immJ;
                nextDec.srcASel  = srcAPc;
                nextDec.isJump   = 1'b1;
                nextDec.regWrite = 1'b1;
            end
            opJalr: begin
                nextDec.srcASel  = srcAPc;
                nextDec.isJump   = 1'b1;
                nextDec.jumpReg  = 1'b1;
                nextDec.regWrite = 1'b1;
            end
            opBranch: begin
                // Compare flags come from a subtract
                nextDec.imm      = immB;
                nextDec.aluOp    = aluSub;
                nextDec.isBranch = 1'b1;
            end
            default: begin
                // Unsupported opcode retires with no write
            end
        endcase
        // x0 is never a write target
        nextDec.regWrite = nextDec.regWrite && (nextDec.rd != '0);
    end

    // ********************
    // Decode register
    // ********************
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            dec <= '0;
        end else if (!stall) begin
            dec <= nextDec;
        end else if (squash && dec.valid) begin
            // Held record is the one to drop, so bubble it in place
            dec.valid <= 1'b0;
        end
    end

    // Write port from the result stage never aims at x0
    assert property (@(posedge Clk) disable iff (!rstN)
        wrEn |-> (wrAddr != '0));

endmodule

/* execute/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  rvIsaPkg::aluOpE               aluOp,
    input  logic [rvIsaPkg::xlen-1:0]     opA,
    input  logic [rvIsaPkg::xlen-1:0]     opB,
    output logic [rvIsaPkg::xlen-1:0]     result,
    output logic                          lessSigned,
    output logic                          lessUnsigned,
    output logic                          equal
);
    import rvIsaPkg::*;

    logic [4:0] shamt;

    assign shamt = opB[4:0];

    // Compare flags, shared with branch resolution
    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;
    assign equal        = opA == opB;

    always_comb begin
        case (aluOp)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluSll:   result = opA << shamt;
            aluSlt:   result = {{(xlen-1){1'b0}}, lessSigned};
            aluSltu:  result = {{(xlen-1){1'b0}}, lessUnsigned};
            aluXor:   result = opA ^ opB;
            aluSrl:   result = opA >> shamt;
            aluSra:   result = $unsigned($signed(opA) >>> shamt);
            aluOr:    result = opA | opB;
            aluAnd:   result = opA & opB;
            aluPassB: result = opB;
            default:  result = opA + opB;
        endcase
    end

endmodule

/* execute/execStage.sv */
`timescale 1ns/1ps

module execStage (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             stall,
    input  pipePkg::decodedT dec,
    input  pipePkg::execT    wbFwd,
    output pipePkg::execT    ex,
    output logic             squash
);
    import rvIsaPkg::*;
    import pipePkg::*;

    logic [xlen-1:0] rs1Val, rs2Val;
    logic [xlen-1:0] opA, opB, aluResult;
    logic [xlen-1:0] targetSum, target;
    logic            lessSigned, lessUnsigned, equal;
    logic            liveValid, taken;

    // Youngest producer wins, then the result stage, then the register file
    function automatic logic [xlen-1:0] pickOperand(
        input logic [regAddrW-1:0] idx,
        input logic [xlen-1:0]     regData,
        input execT                exRec,
        input execT                wbRec
    );
        if (exRec.valid && exRec.regWrite && (exRec.rd == idx) && (idx != '0)) begin
            return exRec.result;
        end
        if (wbRec.valid && wbRec.regWrite && (wbRec.rd == idx) && (idx != '0)) begin
            return wbRec.result;
        end
        return regData;
    endfunction

    // Record after a taken transfer is dead
    assign liveValid = dec.valid && !squash;

    // ********************
    // Operand selection
    // ********************
    assign rs1Val = pickOperand(dec.rs1, dec.rs1Data, ex, wbFwd);
    assign rs2Val = pickOperand(dec.rs2, dec.rs2Data, ex, wbFwd);

    always_comb begin
        case (dec.srcASel)
            srcAPc:   opA = dec.pc;
            srcAZero: opA = '0;
            default:  opA = rs1Val;
        endcase
        opB = (dec.srcBSel == srcBImm) ? dec.imm : rs2Val;
        // Link value for JAL and JALR
        if (dec.isJump) begin
            opA = dec.pc;
            opB = 32'd4;
        end
    end

    aluUnit alu0 (
        .aluOp        (dec.aluOp),
        .opA          (opA),
        .opB          (opB),
        .result       (aluResult),
        .lessSigned   (lessSigned),
        .lessUnsigned (lessUnsigned),
        .equal        (equal)
    );

    // ********************
    // Branch resolution
    // ********************
    always_comb begin
        taken = 1'b0;
        if (liveValid && dec.isJump) begin
            taken = 1'b1;
        end else if (liveValid && dec.isBranch) begin
            case (dec.branchCond)
                brEq:    taken = equal;
                brNe:    taken = !equal;
                brLt:    taken = lessSigned;
                brGe:    taken = !lessSigned;
                brLtu:   taken = lessUnsigned;
                brGeu:   taken = !lessUnsigned;
                default: taken = 1'b0;
            endcase
        end
    end

    // JALR adds to rs1 and drops bit 0
    assign targetSum = (dec.jumpReg ? rs1Val : dec.pc) + dec.imm;
    assign target    = dec.jumpReg ? {targetSum[xlen-1:1], 1'b0} : targetSum;

    // Execute register
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ex <= '0;
        end else if (!stall) begin
            ex.valid    <= liveValid;
            ex.pc       <= dec.pc;
            ex.result   <= aluResult;
            ex.regWrite <= liveValid && dec.regWrite;
            ex.rd       <= dec.rd;
            ex.taken    <= taken;
            ex.target   <= target;
        end
    end

    // Squash flag, held across bubbles and stalls until a record absorbs it
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            squash <= 1'b0;
        end else if (squash && dec.valid) begin
            squash <= 1'b0;
        end else if (!stall && taken) begin
            squash <= 1'b1;
        end
    end

    assert property (@(posedge Clk) disable iff (!rstN)
        (ex.valid && ex.taken) |-> (ex.target[1:0] == 2'b00));

endmodule

/* design/resultStage.sv */
`timescale 1ns/1ps

module resultStage (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic                          stall,
    input  pipePkg::execT                 ex,
    input  logic                          retReady,
    output logic                          retValid,
    output pipePkg::retireT               retData,
    output logic                          wrEn,
    output logic [rvIsaPkg::regAddrW-1:0] wrAddr,
    output logic [rvIsaPkg::xlen-1:0]     wrData,
    output pipePkg::execT                 wbFwd
);
    import pipePkg::*;

    execT resReg;

    // Result register
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            resReg <= '0;
        end else if (!stall) begin
            resReg <= ex;
        end
    end

    // Retire port
    assign retValid         = resReg.valid;
    assign retData.pc       = resReg.pc;
    assign retData.rd       = resReg.rd;
    assign retData.regWrite = resReg.regWrite;
    assign retData.data     = resReg.result;
    assign retData.taken    = resReg.taken;
    assign retData.target   = resReg.target;

    // Write once, on the handoff edge
    assign wrEn   = resReg.valid && resReg.regWrite && retReady;
    assign wrAddr = resReg.rd;
    assign wrData = resReg.result;

    // Forwarding copy for execute
    assign wbFwd = resReg;

    // Payload holds until taken
    assert property (@(posedge Clk) disable iff (!rstN)
        (retValid && !retReady) |=> (retValid && $stable(retData)));

endmodule

/* design/coreTop.sv */
`timescale 1ns/1ps

module coreTop (
    input  logic                        Clk,
    input  logic                        rstN,
    input  logic                        inValid,
    output logic                        inReady,
    input  logic [rvIsaPkg::instrW-1:0] inInstr,
    input  logic [rvIsaPkg::xlen-1:0]   inPc,
    output logic                        retValid,
    input  logic                        retReady,
    output pipePkg::retireT             retData
);
    import rvIsaPkg::*;
    import pipePkg::*;

    decodedT             dec;
    execT                ex, wbFwd;
    logic                stall, squash, wrEn;
    logic [regAddrW-1:0] wrAddr;
    logic [xlen-1:0]     wrData;

    // ********************
    // Common stall
    // ********************
    // Whole pipe freezes while retire is blocked
    assign stall   = retValid && !retReady;
    assign inReady = !stall;

    instrDecode dec0 (
        .Clk     (Clk),
        .rstN    (rstN),
        .stall   (stall),
        .inValid (inValid),
        .inInstr (inInstr),
        .inPc    (inPc),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .squash  (squash),
        .dec     (dec)
    );

    execStage exec0 (
        .Clk    (Clk),
        .rstN   (rstN),
        .stall  (stall),
        .dec    (dec),
        .wbFwd  (wbFwd),
        .ex     (ex),
        .squash (squash)
    );

    resultStage result0 (
        .Clk      (Clk),
        .rstN     (rstN),
        .stall    (stall),
        .ex       (ex),
        .retReady (retReady),
        .retValid (retValid),
        .retData  (retData),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .wbFwd    (wbFwd)
    );

endmodule

/* sim/coreTb.sv */
`timescale 1ns/1ps

module coreTb;
    import rvIsaPkg::*;
    import pipePkg::*;

    // ********************
    // Stimulus layout
    // ********************
    // Eight words per entry: instr pc squashed rd regWrite data taken target
    localparam int fieldsPerEntry = 8;
    localparam int maxEntries     = 64;

    logic             Clk = 1'b0;
    logic             rstN;
    logic             inValid;
    logic             inReady;
    logic [xlen-1:0]  inInstr;
    logic [xlen-1:0]  inPc;
    logic             retValid;
    logic             retReady;
    retireT           retData;

    logic [31:0] stim [maxEntries*fieldsPerEntry];
    int          numEntries;
    int          inIdx;
    int          errors;
    int          expQ [$];
    integer      seed;
    logic        pending;
    logic        loaded;

    coreTop dut0 (
        .Clk      (Clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inInstr  (inInstr),
        .inPc     (inPc),
        .retValid (retValid),
        .retReady (retReady),
        .retData  (retData)
    );

    // 20 ns period
    always #10 Clk = ~Clk;

    // Single compare point for every field
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Compare one retired record with the oldest live entry
    task automatic checkRetire();
        int    e;
        int    base;
        string tag;
        if (expQ.size() == 0) begin
            errors++;
            $display("Unexpected retire at pc %h, no instruction left to expect", retData.pc);
        end else begin
            e    = expQ.pop_front();
            base = e * fieldsPerEntry;
            tag  = $sformatf("entry %0d pc %h", e, stim[base+1]);
            checkValue({tag, " pc"}, stim[base+1], retData.pc);
            checkValue({tag, " regWrite"}, stim[base+4], {31'b0, retData.regWrite});
            checkValue({tag, " taken"}, stim[base+6], {31'b0, retData.taken});
            // Destination and data only matter for writers
            if (stim[base+4] != 32'd0) begin
                checkValue({tag, " rd"}, stim[base+3], {27'b0, retData.rd});
                checkValue({tag, " data"}, stim[base+5], retData.data);
            end
            // Target only meaningful on a redirect
            if (stim[base+6] != 32'd0) begin
                checkValue({tag, " target"}, stim[base+7], retData.target);
            end
        end
    endtask

    // ********************
    // One cycle of driving and monitoring
    // ********************
    task automatic stepCycle();
        @(negedge Clk);
        // Retire back-pressure, low about a third of the time
        retReady = (($random(seed) % 3) != 0);
        // Offered instruction stays put until accepted
        if (!pending) begin
            if ((inIdx < numEntries) && (($random(seed) % 3) != 0)) begin
                inValid = 1'b1;
                inInstr = stim[inIdx*fieldsPerEntry];
                inPc    = stim[inIdx*fieldsPerEntry+1];
            end else begin
                inValid = 1'b0;
            end
        end
        // Let combinational outputs settle
        #1;
        if (inReady !== !(retValid && !retReady)) begin
            errors++;
            $display("inReady did not follow the retire stall at time %0t", $time);
        end
        // Handshakes that complete on the coming rising edge
        if (inValid && inReady) begin
            inIdx++;
            pending = 1'b0;
        end else begin
            pending = inValid;
        end
        if (retValid && retReady) begin
            checkRetire();
        end
    endtask

    // ********************
    // Main sequence
    // ********************
    initial begin
        rstN     = 1'b0;
        inValid  = 1'b0;
        inInstr  = '0;
        inPc     = '0;
        retReady = 1'b0;
        errors   = 0;
        inIdx    = 0;
        pending  = 1'b0;
        loaded   = 1'b0;
        seed     = 92519;
        numEntries = 0;

        // Zero words mark the end of the list
        for (int i = 0; i < maxEntries*fieldsPerEntry; i++) begin
            stim[i] = '0;
        end
        $readmemh("sim/coreStimulus.txt", stim);
        while ((numEntries < maxEntries) && (stim[numEntries*fieldsPerEntry] != 32'd0)) begin
            numEntries++;
        end
        // Squashed entries never retire
        for (int i = 0; i < numEntries; i++) begin
            if (stim[i*fieldsPerEntry+2] == 32'd0) begin
                expQ.push_back(i);
            end
        end
        if (numEntries == 0) begin
            errors++;
            $display("No stimulus entries could be read");
        end
        loaded = 1'b1;

        // Two cycles of reset
        repeat (2) @(negedge Clk);
        rstN = 1'b1;

        while (!((inIdx == numEntries) && (expQ.size() == 0))) begin
            stepCycle();
        end
        // Extra cycles catch duplicated or stray retires
        repeat (10) stepCycle();

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // ********************
    // Watchdog
    // ********************
    initial begin
        wait (loaded);
        repeat (numEntries*20 + 100) @(posedge Clk);
        $display("Timeout: retirement stalled with %0d records still expected", expQ.size());
        $display("Something failed");
        $finish;
    end

endmodule

/* sim/coreStimulus.txt */
// Columns: instr pc squashed rd regWrite data taken target
// Registers start at zero, branches and jumps skip one squashed slot
00500093 00000100 0 01 1 00000005 0 00000000
FFD00113 00000104 0 02 1 FFFFFFFD 0 00000000
002081B3 00000108 0 03 1 00000002 0 00000000
40208233 0000010C 0 04 1 00000008 0 00000000
003092B3 00000110 0 05 1 00000014 0 00000000
00112333 00000114 0 06 1 00000001 0 00000000
001133B3 00000118 0 07 1 00000000 0 00000000
40115413 0000011C 0 08 1 FFFFFFFE 0 00000000
00415493 00000120 0 09 1 0FFFFFFF 0 00000000
0FF0C513 00000124 0 0A 1 000000FA 0 00000000
0F017593 00000128 0 0B 1 000000F0 0 00000000
12345637 0000012C 0 0C 1 12345000 0 00000000
00001697 00000130 0 0D 1 00001130 0 00000000
00708013 00000134 0 00 0 00000000 0 00000000
00100733 00000138 0 0E 1 00000005 0 00000000
00170793 0000013C 0 0F 1 00000006 0 00000000
00E78833 00000140 0 10 1 0000000B 0 00000000
00370893 00000144 0 11 1 00000008 0 00000000
00E08463 00000148 0 00 0 00000000 1 00000150
05500A13 0000014C 1 00 0 00000000 0 00000000
00208463 00000150 0 00 0 00000000 0 00000000
00209463 00000154 0 00 0 00000000 1 0000015C
05500A13 00000158 1 00 0 00000000 0 00000000
00E09463 0000015C 0 00 0 00000000 0 00000000
00114463 00000160 0 00 0 00000000 1 00000168
05500A13 00000164 1 00 0 00000000 0 00000000
0020C463 00000168 0 00 0 00000000 0 00000000
0020D463 0000016C 0 00 0 00000000 1 00000174
05500A13 00000170 1 00 0 00000000 0 00000000
00115463 00000174 0 00 0 00000000 0 00000000
0020E463 00000178 0 00 0 00000000 1 00000180
05500A13 0000017C 1 00 0 00000000 0 00000000
00116463 00000180 0 00 0 00000000 0 00000000
00117463 00000184 0 00 0 00000000 1 0000018C
05500A13 00000188 1 00 0 00000000 0 00000000
0020F463 0000018C 0 00 0 00000000 0 00000000
0080096F 00000190 0 12 1 00000194 1 00000198
05500A13 00000194 1 00 0 00000000 0 00000000
011909E7 00000198 0 13 1 0000019C 1 000001A4
05500A13 000001A0 1 00 0 00000000 0 00000000
013A0AB3 000001A4 0 15 1 0000019C 0 00000000

/* verilog.f */
common/rvIsaPkg.sv
common/pipePkg.sv
decode/regFile.sv
decode/instrDecode.sv
execute/aluUnit.sv
execute/execStage.sv
design/resultStage.sv
design/coreTop.sv
sim/coreTb.sv

/* runSim.sh */
#!/bin/bash
# Build with Verilator, run, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary -f verilog.f --top-module coreTb -o coreSim > build.log 2>&1 \
    && ./obj_dir/coreSim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "Something failed" sim.log \
    && grep -q "Everything OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation or build failed, see build.log and sim.log"; exit 1; }
